/* design/BridgePkg.sv */
package BridgePkg;

//--------------------------------------------------------------------------
// word types
//--------------------------------------------------------------------------
	// data or address word on wishbone and on the system bus
	typedef logic [31:0] busWord_t;
	// wishbone register index
	typedef logic [1:0]  csrAdr_t;

//--------------------------------------------------------------------------
// register map
//--------------------------------------------------------------------------
	localparam csrAdr_t CSR_DATA   = 2'd0;	// pending data word
	localparam csrAdr_t CSR_ADRS   = 2'd1;	// write pushes data + address
	localparam csrAdr_t CSR_STATUS = 2'd2;	// flags, write clears overflow
	localparam csrAdr_t CSR_RDATA  = 2'd3;	// captured read word

	// status bit positions
	localparam int ST_EMPTY   = 0;
	localparam int ST_FULL    = 1;
	localparam int ST_RDVALID = 2;
	localparam int ST_OVF     = 3;

//--------------------------------------------------------------------------
// command queue
//--------------------------------------------------------------------------
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	// pointer wraps by itself, depth is a power of two
	typedef logic [FIFO_PTR_W-1:0] fifoPtr_t;
	// one extra bit so a full queue is distinct from an empty one
	typedef logic [FIFO_PTR_W:0]   fifoCnt_t;

endpackage

/* design/CmdIf.sv */
`timescale 1ns/10ps

// one address/data command with a valid/ready handshake
// transfer when valid and ready are both high at an edge
interface CmdIf;

	// data word for the bus write
	BridgePkg::busWord_t wd;
	// target address, zero is the idle code
	BridgePkg::busWord_t adrs;
	logic                valid;
	logic                ready;

	// producer side, valid must not look at ready
	modport source
	(
		output wd,
		output adrs,
		output valid,
		input  ready
	);

	// consumer side
	modport sink
	(
		input  wd,
		input  adrs,
		input  valid,
		output ready
	);

endinterface

/* design/BridgeCsr.sv */
`timescale 1ns/10ps

module BridgeCsr
(
	input  logic                iSCLK,
	input  logic                iSRST,
	// wishbone classic slave
	input  logic                wbCyc,
	input  logic                wbStb,
	input  logic                wbWe,
	input  BridgePkg::csrAdr_t  wbAdr,
	input  BridgePkg::busWord_t wbDatW,
	output BridgePkg::busWord_t wbDatR,
	output logic                wbAck,
	// command push into the queue
	CmdIf.source                cmd,
	input  logic                fifoEmpty,
	// read data coming back from the system bus
	input  BridgePkg::busWord_t usiRd,
	input  logic                usiRdVd
);

//--------------------------------------------------------------------------
// access decode
//--------------------------------------------------------------------------
logic accessEdge;
logic wrEn;
logic rdEn;
logic pushReq;

// registers
BridgePkg::busWord_t dataReg;
BridgePkg::busWord_t adrsReg;
BridgePkg::busWord_t rdataReg;
BridgePkg::busWord_t statusWord;
logic                rdValid;
logic                overflow;

always_comb
begin
	// new access, ack not raised yet
	accessEdge = wbCyc & wbStb & ~wbAck;
	wrEn       = accessEdge & wbWe;
	rdEn       = accessEdge & ~wbWe;
	// ADRS write turns into a command on the acking edge
	pushReq    = wrEn & (wbAdr == BridgePkg::CSR_ADRS);
end

// one cycle registered ack, low while idle
always_ff @(posedge iSCLK)
begin
	if (iSRST)
		wbAck <= 1'b0;
	else
		wbAck <= accessEdge;
end

//--------------------------------------------------------------------------
// command push
//--------------------------------------------------------------------------
// pending data paired with the address on the bus right now
assign cmd.valid = pushReq;
assign cmd.wd    = dataReg;
assign cmd.adrs  = wbDatW;

//--------------------------------------------------------------------------
// data registers
//--------------------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (wrEn && (wbAdr == BridgePkg::CSR_DATA))
		dataReg <= wbDatW;
	// last address written, readable back
	if (pushReq)
		adrsReg <= wbDatW;
	// capture from the bus on every valid strobe
	if (usiRdVd)
		rdataReg <= usiRd;
end

//--------------------------------------------------------------------------
// flags
//--------------------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		rdValid  <= 1'b0;
		overflow <= 1'b0;
	end
	else
	begin
		// new capture beats the clearing read on the same edge
		if (usiRdVd)
			rdValid <= 1'b1;
		else if (rdEn && (wbAdr == BridgePkg::CSR_RDATA))
			rdValid <= 1'b0;
		// push refused by a full queue
		if (pushReq && !cmd.ready)
			overflow <= 1'b1;
		else if (wrEn && (wbAdr == BridgePkg::CSR_STATUS))
			overflow <= 1'b0;
	end
end

// status word, unused bits read as zero
always_comb
begin
	statusWord                         = '0;
	statusWord[BridgePkg::ST_EMPTY]    = fifoEmpty;
	statusWord[BridgePkg::ST_FULL]     = ~cmd.ready;
	statusWord[BridgePkg::ST_RDVALID]  = rdValid;
	statusWord[BridgePkg::ST_OVF]      = overflow;
end

//--------------------------------------------------------------------------
// read back
//--------------------------------------------------------------------------
// loaded on the acking edge, valid together with ack
always_ff @(posedge iSCLK)
begin
	if (rdEn)
	begin
		case (wbAdr)
			BridgePkg::CSR_DATA:   wbDatR <= dataReg;
			BridgePkg::CSR_ADRS:   wbDatR <= adrsReg;
			BridgePkg::CSR_STATUS: wbDatR <= statusWord;
			default:               wbDatR <= rdataReg;
		endcase
	end
end

endmodule

/* design/CmdFifo.sv */
`timescale 1ns/10ps

module CmdFifo
(
	input  logic iSCLK,
	input  logic iSRST,
	// push side
	CmdIf.sink   wr,
	// pop side, head shown ahead
	CmdIf.source rd,
	output logic empty
);

//--------------------------------------------------------------------------
// storage
//--------------------------------------------------------------------------
BridgePkg::busWord_t wdMem   [BridgePkg::FIFO_DEPTH];
BridgePkg::busWord_t adrsMem [BridgePkg::FIFO_DEPTH];

BridgePkg::fifoPtr_t wrPtr;
BridgePkg::fifoPtr_t rdPtr;
BridgePkg::fifoCnt_t count;

logic full;
logic push;
logic pop;

// occupancy flags
assign full  = (count == BridgePkg::fifoCnt_t'(BridgePkg::FIFO_DEPTH));
assign empty = (count == '0);

// handshakes
assign wr.ready = ~full;
assign rd.valid = ~empty;
assign push     = wr.valid & wr.ready;
assign pop      = rd.valid & rd.ready;

// head entry, no read latency
assign rd.wd   = wdMem[rdPtr];
assign rd.adrs = adrsMem[rdPtr];

// entry write
always_ff @(posedge iSCLK)
begin
	if (push)
	begin
		wdMem[wrPtr]   <= wr.wd;
		adrsMem[wrPtr] <= wr.adrs;
	end
end

//--------------------------------------------------------------------------
// pointers and count
//--------------------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		wrPtr <= '0;
		rdPtr <= '0;
		count <= '0;
	end
	else
	begin
		if (push)
			wrPtr <= wrPtr + 1'b1;
		if (pop)
			rdPtr <= rdPtr + 1'b1;
		// push and pop together leave the count alone
		case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

endmodule

/* design/BusIssue.sv */
`timescale 1ns/10ps

module BusIssue
(
	input  logic                iSCLK,
	input  logic                iSRST,
	// commands from the queue head
	CmdIf.sink                  cmd,
	// system bus master write
	input  logic                usiRdy,
	output BridgePkg::busWord_t usiWd,
	output BridgePkg::busWord_t usiAdrs
);

//--------------------------------------------------------------------------
// pop control
//--------------------------------------------------------------------------
logic xfer;

// bus ready is the only condition for taking a command
assign cmd.ready = usiRdy;
assign xfer      = cmd.valid & cmd.ready;

//--------------------------------------------------------------------------
// bus drive
//--------------------------------------------------------------------------
// address is a one cycle strobe, zero means idle
// data stays put until the next command
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		usiWd   <= '0;
		usiAdrs <= '0;
	end
	else if (xfer)
	begin
		usiWd   <= cmd.wd;
		usiAdrs <= cmd.adrs;
	end
	else
	begin
		// back to idle, data word kept
		usiAdrs <= '0;
	end
end

// back-to-back pops give consecutive strobes
// one command per cycle at most

endmodule

/* design/McuBusBridge.sv */
`timescale 1ns/10ps

module McuBusBridge
(
	input  logic                iSCLK,
	input  logic                iSRST,
	// wishbone classic slave
	input  logic                wbCyc,
	input  logic                wbStb,
	input  logic                wbWe,
	input  BridgePkg::csrAdr_t  wbAdr,
	input  BridgePkg::busWord_t wbDatW,
	output BridgePkg::busWord_t wbDatR,
	output logic                wbAck,
	// system bus write
	output BridgePkg::busWord_t usiWd,
	output BridgePkg::busWord_t usiAdrs,
	input  logic                usiRdy,
	// system bus read return
	input  BridgePkg::busWord_t usiRd,
	input  logic                usiRdVd
);

//--------------------------------------------------------------------------
// command streams
//--------------------------------------------------------------------------
// register file to queue
CmdIf pushIf();
// queue to bus issue
CmdIf popIf();

logic fifoEmpty;

//--------------------------------------------------------------------------
// stages
//--------------------------------------------------------------------------
// csr block, wishbone side
BridgeCsr BridgeCsr
(
	.iSCLK     (iSCLK),
	.iSRST     (iSRST),
	.wbCyc     (wbCyc),
	.wbStb     (wbStb),
	.wbWe      (wbWe),
	.wbAdr     (wbAdr),
	.wbDatW    (wbDatW),
	.wbDatR    (wbDatR),
	.wbAck     (wbAck),
	.cmd       (pushIf.source),
	.fifoEmpty (fifoEmpty),
	.usiRd     (usiRd),
	.usiRdVd   (usiRdVd)
);

// command queue
CmdFifo CmdFifo
(
	.iSCLK (iSCLK),
	.iSRST (iSRST),
	.wr    (pushIf.sink),
	.rd    (popIf.source),
	.empty (fifoEmpty)
);

// bus master
BusIssue BusIssue
(
	.iSCLK   (iSCLK),
	.iSRST   (iSRST),
	.cmd     (popIf.sink),
	.usiRdy  (usiRdy),
	.usiWd   (usiWd),
	.usiAdrs (usiAdrs)
);

endmodule

/* sim/BridgeTbTop.sv */
`timescale 1ns/10ps

module BridgeTbTop;

logic                iSCLK;
logic                iSRST;
logic                wbCyc;
logic                wbStb;
logic                wbWe;
BridgePkg::csrAdr_t  wbAdr;
BridgePkg::busWord_t wbDatW;
BridgePkg::busWord_t wbDatR;
logic                wbAck;
BridgePkg::busWord_t usiWd;
BridgePkg::busWord_t usiAdrs;
logic                usiRdy;
BridgePkg::busWord_t usiRd;
logic                usiRdVd;

// accepted commands as {adrs, wd} in push order
logic [63:0] expQ [$];
int          errCnt = 0;
int          errMark = 0;
int          passCnt = 0;
int          failCnt = 0;
int          strobeCnt = 0;
time         strobeTime;
time         ackTime;
// address of the most recent ADRS write
BridgePkg::busWord_t lastAdrs;

McuBusBridge UUT (.*);

initial
begin
	iSCLK = 1'b0;
	forever #4 iSCLK = ~iSCLK;
end

//--------------------------------------------------------------------------
// protocol checks
//--------------------------------------------------------------------------
// new request gets ack on the next edge
ackFollowsReq: assert property (@(posedge iSCLK) disable iff (iSRST)
	(wbCyc && wbStb && !wbAck) |=> wbAck)
else
begin
	$display("FAILED at %0t: wbAck expected 1, got 0", $time);
	errCnt++;
end

// ack is a single cycle pulse
ackOneCycle: assert property (@(posedge iSCLK) disable iff (iSRST) wbAck |=> !wbAck)
else
begin
	$display("FAILED at %0t: wbAck expected 0, got 1", $time);
	errCnt++;
end

// address strobe never holds one address for two cycles
strobeOneCycle: assert property (@(posedge iSCLK) disable iff (iSRST)
	(usiAdrs != '0) |=> (usiAdrs != $past(usiAdrs)))
else
begin
	$display("FAILED at %0t: usiAdrs expected 0 or a new address, got %h", $time, usiAdrs);
	errCnt++;
end

task automatic checkVal(input string name, input BridgePkg::busWord_t exp,
	input BridgePkg::busWord_t got);
	assert (got === exp)
	else
	begin
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
		errCnt++;
	end
endtask

// expected status word from the four flags in bits 0 to 3
function automatic BridgePkg::busWord_t statusExp(input logic emp, full, rdv, ovf);
	return BridgePkg::busWord_t'({ovf, rdv, full, emp});
endfunction

//--------------------------------------------------------------------------
// bus monitor
//--------------------------------------------------------------------------
// each strobe must match the oldest accepted command
always @(posedge iSCLK)
begin
	if (!iSRST && usiAdrs != '0)
	begin
		strobeCnt++;
		strobeTime = $time;
		if (expQ.size() == 0)
		begin
			$display("unexpected bus write to address %h at %0t", usiAdrs, $time);
			errCnt++;
		end
		else
		begin
			checkVal("usiAdrs", expQ[0][63:32], usiAdrs);
			checkVal("usiWd", expQ[0][31:0], usiWd);
			void'(expQ.pop_front());
		end
	end
end

//--------------------------------------------------------------------------
// host side tasks
//--------------------------------------------------------------------------
// entered and left 1 ns after an edge
task automatic wbAccess(input logic we, input BridgePkg::csrAdr_t adr,
	input BridgePkg::busWord_t dat, output BridgePkg::busWord_t rd);
	int n;
	wbCyc  = 1'b1;
	wbStb  = 1'b1;
	wbWe   = we;
	wbAdr  = adr;
	wbDatW = dat;
	n      = 0;
	@(posedge iSCLK);
	while (!wbAck && n < 16)
	begin
		@(posedge iSCLK);
		n++;
	end
	if (!wbAck)
	begin
		$display("timeout: no wbAck for register %0d", adr);
		errCnt++;
	end
	// edge where ack is seen is one after the edge that raised it
	ackTime = $time;
	rd      = wbDatR;
	#1;
	wbCyc = 1'b0;
	wbStb = 1'b0;
	wbWe  = 1'b0;
endtask

task automatic wbWrite(input BridgePkg::csrAdr_t adr, input BridgePkg::busWord_t dat);
	BridgePkg::busWord_t unused;
	wbAccess(1'b1, adr, dat, unused);
endtask

task automatic wbRead(input BridgePkg::csrAdr_t adr, output BridgePkg::busWord_t rd);
	wbAccess(1'b0, adr, '0, rd);
endtask

// push a random command and record it unless keep is 0
task automatic pushCmd(input logic keep);
	BridgePkg::busWord_t wd;
	BridgePkg::busWord_t adrs;
	wd   = $urandom;
	adrs = $urandom;
	// zero is the idle code
	if (adrs == '0)
		adrs = 32'h1;
	wbWrite(BridgePkg::CSR_DATA, wd);
	wbWrite(BridgePkg::CSR_ADRS, adrs);
	lastAdrs = adrs;
	if (keep)
		expQ.push_back({adrs, wd});
endtask

task automatic idle(input int n);
	repeat (n)
		@(posedge iSCLK);
	#1;
endtask

// until every accepted command was seen on the bus
task automatic waitDrain();
	int n;
	n = 0;
	while (expQ.size() != 0 && n < 64)
	begin
		@(posedge iSCLK);
		#1;
		n++;
	end
	if (expQ.size() != 0)
	begin
		$display("timeout: %0d commands never reached the bus", expQ.size());
		errCnt++;
	end
endtask

task automatic endTest(input string name);
	$display("test %s: %s", name, (errCnt == errMark) ? "ok" : "with errors");
	if (errCnt == errMark)
		passCnt++;
	else
		failCnt++;
	errMark = errCnt;
endtask

//--------------------------------------------------------------------------
// tests
//--------------------------------------------------------------------------
initial
begin
	int                  strobeMark;
	BridgePkg::busWord_t word;
	BridgePkg::busWord_t capWord;

	void'($urandom(32'hf7f504e1));
	iSRST   = 1'b1;
	wbCyc   = 1'b0;
	wbStb   = 1'b0;
	wbWe    = 1'b0;
	wbAdr   = '0;
	wbDatW  = '0;
	usiRdy  = 1'b1;
	usiRd   = '0;
	usiRdVd = 1'b0;
	repeat (3)
		@(posedge iSCLK);
	#1;
	iSRST = 1'b0;

	// idle bus and empty queue
	checkVal("wbAck", 32'h0, BridgePkg::busWord_t'(wbAck));
	checkVal("usiAdrs", 32'h0, usiAdrs);
	checkVal("usiWd", 32'h0, usiWd);
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b1, 1'b0, 1'b0, 1'b0), word);
	endTest("reset state");

	strobeMark = strobeCnt;
	pushCmd(1'b1);
	waitDrain();
	idle(2);
	checkVal("strobe count", 32'd1, BridgePkg::busWord_t'(strobeCnt - strobeMark));
	// cycles from the edge that raised the ADRS ack to the strobe
	checkVal("strobe delay", 32'd2, BridgePkg::busWord_t'((strobeTime - ackTime) / 8 + 1));
	// last address written reads back
	wbRead(BridgePkg::CSR_ADRS, word);
	checkVal("ADRS", lastAdrs, word);
	endTest("single command");

	// bus stalled so the queue fills up
	usiRdy     = 1'b0;
	strobeMark = strobeCnt;
	repeat (BridgePkg::FIFO_DEPTH)
		pushCmd(1'b1);
	idle(3);
	checkVal("strobe count", 32'd0, BridgePkg::busWord_t'(strobeCnt - strobeMark));
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b0, 1'b1, 1'b0, 1'b0), word);
	usiRdy = 1'b1;
	waitDrain();
	idle(2);
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b1, 1'b0, 1'b0, 1'b0), word);
	endTest("order and back-pressure");

	usiRdy = 1'b0;
	repeat (BridgePkg::FIFO_DEPTH)
		pushCmd(1'b1);
	// one too many is dropped
	pushCmd(1'b0);
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b0, 1'b1, 1'b0, 1'b1), word);
	usiRdy = 1'b1;
	waitDrain();
	idle(4);
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b1, 1'b0, 1'b0, 1'b1), word);
	wbWrite(BridgePkg::CSR_STATUS, 32'h0);
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b1, 1'b0, 1'b0, 1'b0), word);
	endTest("overflow");

	// one cycle of read return
	capWord = $urandom;
	usiRd   = capWord;
	usiRdVd = 1'b1;
	idle(1);
	usiRdVd = 1'b0;
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b1, 1'b0, 1'b1, 1'b0), word);
	wbRead(BridgePkg::CSR_RDATA, word);
	checkVal("RDATA", capWord, word);
	wbRead(BridgePkg::CSR_STATUS, word);
	checkVal("STATUS", statusExp(1'b1, 1'b0, 1'b0, 1'b0), word);
	endTest("read capture");

	// pending data word written and read back
	capWord = $urandom;
	wbWrite(BridgePkg::CSR_DATA, capWord);
	wbRead(BridgePkg::CSR_DATA, word);
	checkVal("DATA", capWord, word);
	endTest("wishbone protocol");

	$display("tests passed: %0d, tests failed: %0d", passCnt, failCnt);
	if (failCnt == 0 && errCnt == 0)
		$display("All tests passed");
	else
		$display("Some tests failed");
	$finish;
end

endmodule

/* project.f */
design/BridgePkg.sv
design/CmdIf.sv
design/BridgeCsr.sv
design/CmdFifo.sv
design/BusIssue.sv
design/McuBusBridge.sv
sim/BridgeTbTop.sv

/* run.sh */
#!/bin/bash
# build the bridge testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert -f project.f --top-module BridgeTbTop -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
